// ==== src/axi_mem_pkg.sv ====
// AXI memory path constants
// Channel word widths, memory geometry, access latency, register stage
// count, response codes and the slave FSM state codes
package axi_mem_pkg;

    // Word address, data, byte strobe and transaction id widths
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W = 4;

    // Implemented words. Anything at or above MEM_DEPTH answers with SLVERR
    localparam int MEM_DEPTH = 256;
    localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

    // Modelled access time in cycles, and the counter width it needs
    localparam int MEM_LATENCY = 3;
    localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);

    // Register stages between the master ports and the slave, zero is legal
    localparam int N_REG_STAGES = 2;

    // Channel words, id always in the top bits
    localparam int AW_W = ID_W + ADDR_W;
    localparam int W_W = DATA_W + STRB_W;
    localparam int B_W = ID_W + 2;
    localparam int AR_W = ID_W + ADDR_W;
    localparam int R_W = ID_W + 2 + DATA_W;

    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // Slave FSM states
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_WR_WAIT = 3'd1;
    localparam logic [2:0] ST_WR_RESP = 3'd2;
    localparam logic [2:0] ST_RD_WAIT = 3'd3;
    localparam logic [2:0] ST_RD_RESP = 3'd4;

endpackage

// ==== src/ready_enable_fifo.sv ====
// Two-entry ready/enable register stage
// Both the valid/data path and the ready path are registered, so a chain
// of these stages closes timing in both directions at full throughput
module ready_enable_fifo
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic clk,
    input  logic rst,

    input  logic enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic ready_to_src,

    output logic enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic ready_from_dst
);

    // Second entry. It only fills while the output entry is stalled
    logic skid_valid;
    logic [N_DATA_BITS-1:0] skid_data;

    logic in_xfer;
    logic out_free;
    logic full;

    // Ready depends only on a flop and never on ready_from_dst
    assign ready_to_src = !skid_valid;
    assign in_xfer = enable_from_src && ready_to_src;

    // The output entry can take new data when empty or when it drains now
    assign out_free = !enable_to_dst || ready_from_dst;
    assign full = enable_to_dst && skid_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_to_dst <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_free)
        begin
            // The skid entry drains first. No input arrives while it is full
            enable_to_dst <= skid_valid || in_xfer;
            skid_valid <= 1'b0;
        end
        else if (in_xfer)
        begin
            skid_valid <= 1'b1;
        end
    end

    // Payload registers follow the valid bits above
    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            data_to_dst <= skid_valid ? skid_data : data_from_src;
        end

        if (!out_free && in_xfer)
        begin
            skid_data <= data_from_src;
        end
    end

    // A free entry must always show as ready. This breaks if the skid entry
    // ever holds data behind an empty output entry
    assert property (@(posedge clk) disable iff (rst) !full |-> ready_to_src)
        else $error("ready_enable_fifo: ready low while an entry is free");

endmodule

// ==== src/axi_mem_if_reg.sv ====
// AXI register path
// Inserts N_REG_STAGES ready/enable stages on each of the five channels
// between the master ports and the s_ slave ports. Zero stages is a wire path
module axi_mem_if_reg
    import axi_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // Master side
    input  logic awvalid,
    input  logic [AW_W-1:0] aw,
    output logic awready,
    input  logic wvalid,
    input  logic [W_W-1:0] w,
    output logic wready,
    output logic bvalid,
    output logic [B_W-1:0] b,
    input  logic bready,
    input  logic arvalid,
    input  logic [AR_W-1:0] ar,
    output logic arready,
    output logic rvalid,
    output logic [R_W-1:0] r,
    input  logic rready,

    // Slave side
    output logic s_awvalid,
    output logic [AW_W-1:0] s_aw,
    input  logic s_awready,
    output logic s_wvalid,
    output logic [W_W-1:0] s_w,
    input  logic s_wready,
    input  logic s_bvalid,
    input  logic [B_W-1:0] s_b,
    output logic s_bready,
    output logic s_arvalid,
    output logic [AR_W-1:0] s_ar,
    input  logic s_arready,
    input  logic s_rvalid,
    input  logic [R_W-1:0] s_r,
    output logic s_rready
);

    // Index 0 is the slave end and index N_REG_STAGES the master end.
    // With no stages both ends are the same element and the path is wires
    logic [N_REG_STAGES:0] awvalid_p, awready_p, wvalid_p, wready_p;
    logic [N_REG_STAGES:0] bvalid_p, bready_p;
    logic [N_REG_STAGES:0] arvalid_p, arready_p, rvalid_p, rready_p;
    logic [N_REG_STAGES:0][AW_W-1:0] aw_p;
    logic [N_REG_STAGES:0][W_W-1:0] w_p;
    logic [N_REG_STAGES:0][B_W-1:0] b_p;
    logic [N_REG_STAGES:0][AR_W-1:0] ar_p;
    logic [N_REG_STAGES:0][R_W-1:0] r_p;

    // Master end of the chain
    assign awvalid_p[N_REG_STAGES] = awvalid;
    assign aw_p[N_REG_STAGES] = aw;
    assign awready = awready_p[N_REG_STAGES];
    assign wvalid_p[N_REG_STAGES] = wvalid;
    assign w_p[N_REG_STAGES] = w;
    assign wready = wready_p[N_REG_STAGES];
    assign bvalid = bvalid_p[N_REG_STAGES];
    assign b = b_p[N_REG_STAGES];
    assign bready_p[N_REG_STAGES] = bready;
    assign arvalid_p[N_REG_STAGES] = arvalid;
    assign ar_p[N_REG_STAGES] = ar;
    assign arready = arready_p[N_REG_STAGES];
    assign rvalid = rvalid_p[N_REG_STAGES];
    assign r = r_p[N_REG_STAGES];
    assign rready_p[N_REG_STAGES] = rready;

    // Slave end of the chain
    assign s_awvalid = awvalid_p[0];
    assign s_aw = aw_p[0];
    assign awready_p[0] = s_awready;
    assign s_wvalid = wvalid_p[0];
    assign s_w = w_p[0];
    assign wready_p[0] = s_wready;
    assign bvalid_p[0] = s_bvalid;
    assign b_p[0] = s_b;
    assign s_bready = bready_p[0];
    assign s_arvalid = arvalid_p[0];
    assign s_ar = ar_p[0];
    assign arready_p[0] = s_arready;
    assign rvalid_p[0] = s_rvalid;
    assign r_p[0] = s_r;
    assign s_rready = rready_p[0];

    // Requests move from s toward s-1, responses from s-1 toward s
    for (genvar s = 1; s <= N_REG_STAGES; s++)
    begin : stage
        ready_enable_fifo #(.N_DATA_BITS(AW_W)) aw_fifo
        (
            .clk, .rst,
            .enable_from_src(awvalid_p[s]), .data_from_src(aw_p[s]), .ready_to_src(awready_p[s]),
            .enable_to_dst(awvalid_p[s-1]), .data_to_dst(aw_p[s-1]),
            .ready_from_dst(awready_p[s-1])
        );

        ready_enable_fifo #(.N_DATA_BITS(W_W)) w_fifo
        (
            .clk, .rst,
            .enable_from_src(wvalid_p[s]), .data_from_src(w_p[s]), .ready_to_src(wready_p[s]),
            .enable_to_dst(wvalid_p[s-1]), .data_to_dst(w_p[s-1]), .ready_from_dst(wready_p[s-1])
        );

        ready_enable_fifo #(.N_DATA_BITS(B_W)) b_fifo
        (
            .clk, .rst,
            .enable_from_src(bvalid_p[s-1]), .data_from_src(b_p[s-1]),
            .ready_to_src(bready_p[s-1]),
            .enable_to_dst(bvalid_p[s]), .data_to_dst(b_p[s]), .ready_from_dst(bready_p[s])
        );

        ready_enable_fifo #(.N_DATA_BITS(AR_W)) ar_fifo
        (
            .clk, .rst,
            .enable_from_src(arvalid_p[s]), .data_from_src(ar_p[s]), .ready_to_src(arready_p[s]),
            .enable_to_dst(arvalid_p[s-1]), .data_to_dst(ar_p[s-1]),
            .ready_from_dst(arready_p[s-1])
        );

        ready_enable_fifo #(.N_DATA_BITS(R_W)) r_fifo
        (
            .clk, .rst,
            .enable_from_src(rvalid_p[s-1]), .data_from_src(r_p[s-1]),
            .ready_to_src(rready_p[s-1]),
            .enable_to_dst(rvalid_p[s]), .data_to_dst(r_p[s]), .ready_from_dst(rready_p[s])
        );
    end

endmodule

// ==== src/mem_latency_timer.sv ====
// Memory access latency timer
// Raises timer_done for one cycle MEM_LATENCY cycles after timer_start
module mem_latency_timer
    import axi_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic timer_done
);

    logic busy;
    logic [LAT_CNT_W-1:0] count;

    // Done is the cycle where a running count has reached zero
    assign timer_done = busy && (count == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            count <= '0;
        end
        else if (timer_start)
        begin
            // The start cycle itself counts as the first latency cycle
            busy <= 1'b1;
            count <= LAT_CNT_W'(MEM_LATENCY - 1);
        end
        else if (timer_done)
        begin
            busy <= 1'b0;
        end
        else if (busy)
        begin
            count <= count - 1'b1;
        end
    end

    // The FSM only starts an access from idle, after the last one finished
    assert property (@(posedge clk) disable iff (rst) timer_start |-> !busy)
        else $error("mem_latency_timer: start while the count is running");

endmodule

// ==== src/mem_array.sv ====
// On-chip word memory
// Byte-strobe writes, registered reads and the address range check.
// Out-of-range writes are dropped and out-of-range reads return zero
module mem_array
    import axi_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic mem_wr_en,
    input  logic mem_rd_en,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic [STRB_W-1:0] mem_wstrb,
    output logic [DATA_W-1:0] mem_rdata,
    output logic mem_in_range
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [MEM_IDX_W-1:0] idx;

    // Compare at full int width so a depth of 2**ADDR_W still works
    assign mem_in_range = (int'(mem_addr) < MEM_DEPTH);
    assign idx = mem_addr[MEM_IDX_W-1:0];

    // Only the strobed bytes of the word change
    always_ff @(posedge clk)
    begin
        if (mem_wr_en && mem_in_range)
        begin
            for (int i = 0; i < STRB_W; i++)
            begin
                if (mem_wstrb[i])
                    mem[idx][8*i +: 8] <= mem_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            mem_rdata <= '0;
        else if (mem_rd_en)
            mem_rdata <= mem_in_range ? mem[idx] : '0;
    end

endmodule

// ==== src/mem_ctrl_fsm.sv ====
// Memory slave controller
// Accepts one write (aw with w) or one read (ar) at a time, alternating
// when both wait, runs the latency timer and returns the b or r response
module mem_ctrl_fsm
    import axi_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic s_awvalid,
    input  logic [AW_W-1:0] s_aw,
    output logic s_awready,
    input  logic s_wvalid,
    input  logic [W_W-1:0] s_w,
    output logic s_wready,
    output logic s_bvalid,
    output logic [B_W-1:0] s_b,
    input  logic s_bready,
    input  logic s_arvalid,
    input  logic [AR_W-1:0] s_ar,
    output logic s_arready,
    output logic s_rvalid,
    output logic [R_W-1:0] s_r,
    input  logic s_rready,

    output logic timer_start,
    input  logic timer_done,

    output logic mem_wr_en,
    output logic mem_rd_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    output logic [STRB_W-1:0] mem_wstrb,
    input  logic [DATA_W-1:0] mem_rdata,
    input  logic mem_in_range
);

    logic [2:0] state;
    logic last_wr;
    logic wr_req;
    logic rd_req;
    logic pick_wr;
    logic pick_rd;
    logic [ID_W-1:0] req_id;
    logic [1:0] resp;

    // A write needs its address and data together
    assign wr_req = s_awvalid && s_wvalid;
    assign rd_req = s_arvalid;

    // On a tie, serve the kind that was not served last
    assign pick_wr = (state == ST_IDLE) && wr_req && (!rd_req || !last_wr);
    assign pick_rd = (state == ST_IDLE) && rd_req && !pick_wr;

    assign s_awready = pick_wr;
    assign s_wready = pick_wr;
    assign s_arready = pick_rd;

    // The timer runs from the accept cycle, memory is touched when it ends
    assign timer_start = pick_wr || pick_rd;
    assign mem_wr_en = (state == ST_WR_WAIT) && timer_done;
    assign mem_rd_en = (state == ST_RD_WAIT) && timer_done;

    // mem_addr is held through the response, so the range check is stable
    assign resp = mem_in_range ? RESP_OKAY : RESP_SLVERR;
    assign s_bvalid = (state == ST_WR_RESP);
    assign s_b = {req_id, resp};
    assign s_rvalid = (state == ST_RD_RESP);
    assign s_r = {req_id, resp, mem_rdata};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            last_wr <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (timer_start)
                    begin
                        state <= pick_wr ? ST_WR_WAIT : ST_RD_WAIT;
                        last_wr <= pick_wr;
                    end
                end
                ST_WR_WAIT:
                    if (timer_done)
                        state <= ST_WR_RESP;
                ST_WR_RESP:
                    if (s_bready)
                        state <= ST_IDLE;
                ST_RD_WAIT:
                    if (timer_done)
                        state <= ST_RD_RESP;
                ST_RD_RESP:
                    if (s_rready)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Request fields captured at accept time
    always_ff @(posedge clk)
    begin
        if (pick_wr)
        begin
            req_id <= s_aw[AW_W-1 -: ID_W];
            mem_addr <= s_aw[ADDR_W-1:0];
            mem_wdata <= s_w[W_W-1 -: DATA_W];
            mem_wstrb <= s_w[STRB_W-1:0];
        end
        else if (pick_rd)
        begin
            req_id <= s_ar[AR_W-1 -: ID_W];
            mem_addr <= s_ar[ADDR_W-1:0];
        end
    end

    // A response, read data included, is held unchanged until taken
    assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_b))
        else $error("mem_ctrl_fsm: b response dropped or changed before bready");

    assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
        else $error("mem_ctrl_fsm: r response dropped or changed before rready");

endmodule

// ==== src/axi_mem_top.sv ====
// Registered AXI memory path, top level
// Master ports pass through the register stages into the memory slave,
// which is the controller FSM, the latency timer and the word memory
module axi_mem_top
    import axi_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic awvalid,
    input  logic [AW_W-1:0] aw,
    output logic awready,
    input  logic wvalid,
    input  logic [W_W-1:0] w,
    output logic wready,
    output logic bvalid,
    output logic [B_W-1:0] b,
    input  logic bready,
    input  logic arvalid,
    input  logic [AR_W-1:0] ar,
    output logic arready,
    output logic rvalid,
    output logic [R_W-1:0] r,
    input  logic rready
);

    // Slave side of the register path
    logic s_awvalid;
    logic [AW_W-1:0] s_aw;
    logic s_awready;
    logic s_wvalid;
    logic [W_W-1:0] s_w;
    logic s_wready;
    logic s_bvalid;
    logic [B_W-1:0] s_b;
    logic s_bready;
    logic s_arvalid;
    logic [AR_W-1:0] s_ar;
    logic s_arready;
    logic s_rvalid;
    logic [R_W-1:0] s_r;
    logic s_rready;

    // Controller to timer and memory
    logic timer_start;
    logic timer_done;
    logic mem_wr_en;
    logic mem_rd_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [STRB_W-1:0] mem_wstrb;
    logic [DATA_W-1:0] mem_rdata;
    logic mem_in_range;

    // Port and signal names match throughout, so the instances connect by name
    axi_mem_if_reg if_reg0 (.*);

    mem_ctrl_fsm ctrl0 (.*);

    mem_latency_timer timer0 (.*);

    mem_array array0 (.*);

endmodule

// ==== testbench/tb_axi_mem_top.sv ====
// Testbench for the registered AXI memory path
// Drives writes and reads through the master ports, keeps a model memory
// and checks every b and r response against it
module tb_axi_mem_top
    import axi_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Twice about 420 operations at up to 20 cycles each under gaps and stalls
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [ADDR_W-1:0] DEPTH_ADDR = ADDR_W'(MEM_DEPTH);

    logic clk, rst;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [AW_W-1:0] aw;
    logic [W_W-1:0] w;
    logic [B_W-1:0] b;
    logic [AR_W-1:0] ar;
    logic [R_W-1:0] r;

    integer seed;
    string test_name;
    logic rand_gaps, rand_ready;
    int cycle_count, wr_sent, b_got, rd_sent, r_got;
    logic [ID_W-1:0] wr_id_next, rd_id_next;
    logic [DATA_W-1:0] model_mem [MEM_DEPTH];

    // Requests still waiting for their response in issue order
    logic [ID_W-1:0] wr_id_q[$], rd_id_q[$];
    logic [ADDR_W-1:0] wr_addr_q[$], rd_addr_q[$];
    logic [DATA_W-1:0] wr_data_q[$];
    logic [STRB_W-1:0] wr_strb_q[$];

    axi_mem_top dut0 (.*);

    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Expected {resp, data} of an access from the model memory
    function automatic logic [DATA_W+1:0] ref_access(input logic [ADDR_W-1:0] addr);
        logic [DATA_W+1:0] result;
        if (addr >= DEPTH_ADDR)
            result = {RESP_SLVERR, {DATA_W{1'b0}}};
        else
            result = {RESP_OKAY, model_mem[addr[MEM_IDX_W-1:0]]};
        return result;
    endfunction

    // Strobed bytes are merged and out-of-range writes leave the model alone
    function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data,
                                        input logic [STRB_W-1:0] strb);
        if (addr < DEPTH_ADDR)
        begin
            for (int i = 0; i < STRB_W; i++)
            begin
                if (strb[i])
                    model_mem[addr[MEM_IDX_W-1:0]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic insert_gap();
        int gap;
        gap = 0;
        if (rand_gaps)
            gap = $random(seed) & 3;
        repeat (gap) @(negedge clk);
    endtask

    // Called on a falling edge and returns on a falling edge
    task automatic send_write(input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
        logic aw_done;
        logic w_done;
        logic [ID_W-1:0] id;
        id = wr_id_next;
        wr_id_next = ID_W'(wr_id_next + 1);
        wr_id_q.push_back(id);
        wr_addr_q.push_back(addr);
        wr_data_q.push_back(data);
        wr_strb_q.push_back(strb);
        wr_sent++;
        awvalid = 1'b1;
        aw = {id, addr};
        wvalid = 1'b1;
        w = {data, strb};
        aw_done = 1'b0;
        w_done = 1'b0;
        // The aw and w stages may take their words on different edges
        while (!(aw_done && w_done))
        begin
            @(posedge clk);
            if (awvalid && awready)
                aw_done = 1'b1;
            if (wvalid && wready)
                w_done = 1'b1;
            @(negedge clk);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
        end
        insert_gap();
    endtask

    task automatic send_read(input logic [ADDR_W-1:0] addr);
        logic [ID_W-1:0] id;
        id = rd_id_next;
        rd_id_next = ID_W'(rd_id_next + 1);
        rd_id_q.push_back(id);
        rd_addr_q.push_back(addr);
        rd_sent++;
        arvalid = 1'b1;
        ar = {id, addr};
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        insert_gap();
    endtask

    task automatic wait_responses();
        while (b_got != wr_sent || r_got != rd_sent)
            @(negedge clk);
    endtask

    // Response ready toggles at random during the stress phases
    always @(negedge clk)
    begin
        if (rand_ready)
        begin
            bready = (($random(seed) & 3) != 0);
            rready = (($random(seed) & 3) != 0);
        end
        else
        begin
            bready = 1'b1;
            rready = 1'b1;
        end
    end

    // Compare every b and r transfer with the reference
    always @(posedge clk)
    begin
        logic [ID_W-1:0] exp_id;
        logic [ADDR_W-1:0] exp_addr;
        logic [DATA_W-1:0] exp_data;
        logic [STRB_W-1:0] exp_strb;
        logic [DATA_W+1:0] exp_acc;
        logic [B_W-1:0] exp_b;
        logic [R_W-1:0] exp_r;
        if (!rst && bvalid && bready)
        begin
            assert (wr_id_q.size() != 0)
                else fail_run("A b response arrived with no write outstanding");
            exp_id = wr_id_q.pop_front();
            exp_addr = wr_addr_q.pop_front();
            exp_data = wr_data_q.pop_front();
            exp_strb = wr_strb_q.pop_front();
            exp_acc = ref_access(exp_addr);
            exp_b = {exp_id, exp_acc[DATA_W+1 -: 2]};
            assert (b === exp_b)
                else fail_run($sformatf("Error: %s b expected %h actual %h",
                                        test_name, exp_b, b));
            model_write(exp_addr, exp_data, exp_strb);
            b_got++;
        end
        if (!rst && rvalid && rready)
        begin
            assert (rd_id_q.size() != 0)
                else fail_run("An r response arrived with no read outstanding");
            exp_id = rd_id_q.pop_front();
            exp_addr = rd_addr_q.pop_front();
            exp_r = {exp_id, ref_access(exp_addr)};
            assert (r === exp_r)
                else fail_run($sformatf("Error: %s r expected %h actual %h",
                                        test_name, exp_r, r));
            r_got++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run("Timeout with responses still missing");
    end

    initial
    begin
        logic [ADDR_W-1:0] addr;
        seed = 46978;
        clk = 1'b0;
        rst = 1'b1;
        {awvalid, wvalid, arvalid} = 3'b000;
        {bready, rready} = 2'b11;
        aw = '0;
        w = '0;
        ar = '0;
        {rand_gaps, rand_ready} = 2'b00;
        {cycle_count, wr_sent, b_got, rd_sent, r_got} = '0;
        wr_id_next = '0;
        rd_id_next = '0;
        test_name = "reset";
        for (int i = 0; i < MEM_DEPTH; i++)
            model_mem[i] = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // No response may appear while the bus is quiet
        repeat (10)
        begin
            @(posedge clk);
            assert (!bvalid && !rvalid)
                else fail_run("A response valid went high before any request");
        end
        @(negedge clk);

        test_name = "write_read_full";
        for (int i = 0; i < 32; i++)
        begin
            addr = ADDR_W'(i * 4);
            send_write(addr, $random(seed), 4'hf);
            wait_responses();
            send_read(addr);
            wait_responses();
        end

        test_name = "partial_strobe";
        for (int i = 0; i < 32; i++)
        begin
            addr = ADDR_W'(i * 4);
            send_write(addr, $random(seed), STRB_W'($random(seed)));
            wait_responses();
            send_read(addr);
            wait_responses();
        end

        // Out-of-range addresses alias in-range words in their low bits
        test_name = "out_of_range";
        for (int i = 0; i < 8; i++)
        begin
            addr = ADDR_W'(MEM_DEPTH + i * 4 + 256 * (i % 3));
            send_write(addr, $random(seed), 4'hf);
            wait_responses();
            send_read(addr);
            send_read(ADDR_W'(i * 4));
            wait_responses();
        end

        test_name = "random_flow";
        {rand_gaps, rand_ready} = 2'b11;
        for (int i = 0; i < 64; i++)
            send_write(ADDR_W'(128 + i), $random(seed), 4'hf);
        wait_responses();
        for (int i = 0; i < 64; i++)
            send_read(ADDR_W'(128 + i));
        wait_responses();

        // Writes hit the lower half only, so the upper half model stays as it was
        test_name = "concurrent";
        fork
            for (int i = 0; i < 64; i++)
                send_write(ADDR_W'($random(seed) & 127), $random(seed), 4'hf);
            for (int j = 0; j < 64; j++)
                send_read(ADDR_W'(128 + ($random(seed) & 63)));
        join
        wait_responses();

        // Quiet period in which no stray response may appear
        {rand_gaps, rand_ready} = 2'b00;
        repeat (20) @(negedge clk);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== all.f ====
src/axi_mem_pkg.sv
src/ready_enable_fifo.sv
src/axi_mem_if_reg.sv
src/mem_latency_timer.sv
src/mem_array.sv
src/mem_ctrl_fsm.sv
src/axi_mem_top.sv
testbench/tb_axi_mem_top.sv

// ==== Makefile ====
# Verilator build and run of the AXI memory path testbench
VERILATOR ?= verilator
TOP ?= tb_axi_mem_top
SEED ?= 0
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# The run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
